//--- list.f
+incdir+sim
source/jpeg_quant_pkg.sv
source/quant_tables.sv
source/quant_mult.sv
source/mcu_tracker.sv
source/sideband_pipe.sv
source/jpeg_quant.sv
sim/tb_jpeg_quant.sv

//--- Makefile
# Verilator build and run for the JPEG quantizer testbench
VERILATOR ?= verilator
TOP       ?= tb_jpeg_quant
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= NO ERRORS
VFLAGS    ?= --binary --timing -j 0 -Wno-fatal

SOURCES   := $(shell grep -v '^+' $(FILELIST))
HEADERS   := sim/quant_model.svh
SIM_BIN   := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- sim/quant_model.svh
`ifndef QUANT_MODEL_SVH
`define QUANT_MODEL_SVH

// rounded 4096/Qstd for the table entry at zigzag index zz
function automatic int expected_factor(input bit chroma_tab, input int zz);
    int raster;
    int qstd;
    raster = int'(jpeg_quant_pkg::ZIGZAG_RASTER[zz]);
    if (chroma_tab) begin
        qstd = int'(jpeg_quant_pkg::STD_CHROMA_Q[raster]);
    end else begin
        qstd = int'(jpeg_quant_pkg::STD_LUMA_Q[raster]);
    end
    return $rtoi(4096.0 / qstd + 0.5);
endfunction

// floor(d*f/4096) truncated to the quantized width
function automatic logic signed [jpeg_quant_pkg::QW-1:0] quantize(input int d, input int f);
    longint prod;
    longint fl;
    prod = longint'(d) * longint'(f);
    fl = prod / 4096;
    // division truncates toward zero, floor is one lower for inexact negatives
    if (prod < 0 && fl * 4096 != prod) begin
        fl = fl - 1;
    end
    return fl[jpeg_quant_pkg::QW-1:0];
endfunction

// number of 16x16 MCUs in a frame
function automatic int mcu_count(input int x_m1, input int y_m1);
    return (x_m1 / 16 + 1) * (y_m1 / 16 + 1);
endfunction

// sideband of a beat, counted from the first beat of a frame
function automatic jpeg_quant_pkg::quant_side_t beat_sideband(input int beat, input int n_mcu);
    jpeg_quant_pkg::quant_side_t s;
    int blk;
    int mcu;
    blk = (beat / 32) % 6;
    mcu = (beat / 192) % n_mcu;
    s.cnt = 5'(beat % 32);
    s.chroma = (blk < 4) ? 2'd0 : ((blk == 4) ? 2'd1 : 2'd2);
    s.last_mcu = (blk == 5) && (mcu == n_mcu - 1);
    return s;
endfunction

`endif

//--- sim/tb_jpeg_quant.sv
`timescale 1ns/1ns

module tb_jpeg_quant;

    localparam int SENSOR_X_SIZE = 1280;
    localparam int SENSOR_Y_SIZE = 720;
    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);
    localparam int DW = jpeg_quant_pkg::DW;
    localparam int NUM_ROWS = 6;
    localparam int DRAIN_LIMIT = 400;
    // enabled cycles from an accepted beat to its result
    localparam int LATENCY = 5;
    localparam int MODE_RAND = 0;
    localparam int MODE_MAXP = 1;
    localparam int MODE_MAXN = 2;
    localparam int MODE_ZERO = 3;

    typedef struct {
        string name;
        int    x_m1;
        int    y_m1;
        int    mode;
        int    hold_div;
        int    frames;
    } row_t;

    // expected result of one accepted beat
    typedef struct packed {
        jpeg_quant_pkg::quant_pair_t q;
        jpeg_quant_pkg::quant_side_t side;
        int unsigned                 stamp;
        int unsigned                 beat;
    } expect_t;

    // hold_div 0 means no hold, otherwise hold 1 in hold_div cycles
    row_t rows [NUM_ROWS] = '{
        '{"rand_2x2_free",  31, 31, MODE_RAND, 0, 2},
        '{"rand_3x1_free",  47, 15, MODE_RAND, 0, 2},
        '{"maxpos_2x2_q4",  31, 31, MODE_MAXP, 4, 1},
        '{"maxneg_3x1_q4",  47, 15, MODE_MAXN, 4, 1},
        '{"zero_2x2_half",  31, 31, MODE_ZERO, 2, 1},
        '{"rand_3x1_half",  47, 15, MODE_RAND, 2, 2}
    };

    logic                        clk;
    logic                        resetn;
    jpeg_quant_pkg::coef_pair_t  di;
    logic                        di_valid;
    logic [4:0]                  di_cnt;
    logic                        di_hold;
    jpeg_quant_pkg::quant_pair_t q;
    logic                        q_valid;
    jpeg_quant_pkg::quant_side_t q_side;
    logic                        q_hold;
    logic [XW-1:0]               x_size_m1;
    logic [YW-1:0]               y_size_m1;

    integer      seed;
    expect_t     exp_q [$];
    string       cur_name = "reset";
    int unsigned en_count = 0;
    int unsigned out_count = 0;
    int unsigned in_count = 0;
    int          errors = 0;
    int          checks = 0;
    logic        aborted = 1'b0;

    `include "quant_model.svh"

    jpeg_quant #(
        .SENSOR_X_SIZE(SENSOR_X_SIZE),
        .SENSOR_Y_SIZE(SENSOR_Y_SIZE)
    ) jpeg_quant_i (
        .clk      (clk),
        .resetn   (resetn),
        .di       (di),
        .di_valid (di_valid),
        .di_cnt   (di_cnt),
        .di_hold  (di_hold),
        .q        (q),
        .q_valid  (q_valid),
        .q_side   (q_side),
        .q_hold   (q_hold),
        .x_size_m1(x_size_m1),
        .y_size_m1(y_size_m1)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic pick_hold(input int hold_div);
        if (hold_div == 0) begin
            return 1'b0;
        end
        return ($unsigned($random(seed)) % hold_div) == 0;
    endfunction

    function automatic logic signed [DW-1:0] make_coef(input int mode);
        case (mode)
            MODE_MAXP: return {1'b0, {(DW-1){1'b1}}};
            MODE_MAXN: return {1'b1, {(DW-1){1'b0}}};
            MODE_ZERO: return '0;
            default:   return DW'($random(seed));
        endcase
    endfunction

    task automatic drive_beat(input int mode, input int beat);
        logic signed [DW-1:0] c0;
        logic signed [DW-1:0] c1;
        c0 = make_coef(mode);
        c1 = make_coef(mode);
        di       <= '{c0: c0, c1: c1};
        di_valid <= 1'b1;
        di_cnt   <= 5'(beat % 32);
    endtask

    task automatic check_value(input string what, input int unsigned beat,
                               input logic signed [31:0] expv, input logic signed [31:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("[FAIL] %s beat %0d %s: expected %0d actual %0d",
                     cur_name, beat, what, expv, actv);
        end
    endtask

    // streams whole frames of one table row, then waits for the pipe to drain
    task automatic stream_row(input int row);
        int      n_mcu;
        int      total;
        int      beat;
        int      cycles;
        bit      tab;
        expect_t e;
        n_mcu = mcu_count(rows[row].x_m1, rows[row].y_m1);
        total = n_mcu * 192 * rows[row].frames;
        beat = 0;
        cycles = 0;
        @(posedge clk);
        cur_name = rows[row].name;
        x_size_m1 <= XW'(rows[row].x_m1);
        y_size_m1 <= YW'(rows[row].y_m1);
        q_hold <= pick_hold(rows[row].hold_div);
        drive_beat(rows[row].mode, 0);
        while (beat < total && cycles < total * 8 + 100) begin
            @(posedge clk);
            cycles++;
            if (di_valid && !q_hold) begin
                e.side = beat_sideband(beat, n_mcu);
                tab = (e.side.chroma != 2'd0);
                e.q.q0 = quantize(di.c0, expected_factor(tab, 2 * e.side.cnt));
                e.q.q1 = quantize(di.c1, expected_factor(tab, 2 * e.side.cnt + 1));
                e.stamp = en_count;
                e.beat = beat;
                exp_q.push_back(e);
                in_count++;
                beat++;
                if (beat < total) begin
                    drive_beat(rows[row].mode, beat);
                end else begin
                    di_valid <= 1'b0;
                end
            end
            q_hold <= pick_hold(rows[row].hold_div);
        end
        if (beat < total) begin
            errors++;
            aborted = 1'b1;
            $display("%s: timed out with %0d of %0d beats accepted", cur_name, beat, total);
        end
        cycles = 0;
        while (out_count != in_count && cycles < DRAIN_LIMIT) begin
            @(posedge clk);
            cycles++;
            q_hold <= pick_hold(rows[row].hold_div);
        end
        if (out_count != in_count) begin
            errors++;
            aborted = 1'b1;
            $display("%s: pipe did not drain, %0d results missing", cur_name,
                     in_count - out_count);
        end
    endtask

    // scoreboard and output protocol checks on the rising edge
    always @(posedge clk) begin : monitor
        expect_t                     e;
        jpeg_quant_pkg::quant_pair_t q_prev;
        jpeg_quant_pkg::quant_side_t side_prev;
        logic                        valid_prev;
        logic                        hold_prev;
        logic                        live_prev;
        if (resetn) begin
            if (!q_hold) begin
                en_count <= en_count + 1;
            end
            checks++;
            if (di_hold !== q_hold) begin
                errors++;
                $display("[FAIL] %s di_hold: expected %b actual %b", cur_name, q_hold, di_hold);
            end
            if (live_prev && hold_prev) begin
                checks++;
                if (q !== q_prev || q_side !== side_prev || q_valid !== valid_prev) begin
                    errors++;
                    $display("[FAIL] %s outputs under hold: expected %h actual %h", cur_name,
                             {valid_prev, q_prev, side_prev}, {q_valid, q, q_side});
                end
            end
            if (q_valid === 1'b1 && !q_hold) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: q_valid high with no accepted beat outstanding", cur_name);
                end else begin
                    e = exp_q.pop_front();
                    out_count <= out_count + 1;
                    check_value("q0", e.beat, e.q.q0, q.q0);
                    check_value("q1", e.beat, e.q.q1, q.q1);
                    check_value("cnt", e.beat, e.side.cnt, q_side.cnt);
                    check_value("chroma", e.beat, e.side.chroma, q_side.chroma);
                    check_value("last_mcu", e.beat, e.side.last_mcu, q_side.last_mcu);
                    // enabled cycles from acceptance to the output
                    check_value("latency", e.beat, LATENCY, en_count - e.stamp);
                end
            end
        end
        q_prev = q;
        side_prev = q_side;
        valid_prev = q_valid;
        hold_prev = q_hold;
        live_prev = resetn;
    end

    initial begin : main
        int row;
        seed = 32'h12da_3ba9;
        resetn = 1'b0;
        di = '0;
        di_valid = 1'b0;
        di_cnt = '0;
        q_hold = 1'b0;
        x_size_m1 = XW'(31);
        y_size_m1 = YW'(31);
        repeat (4) @(posedge clk);
        resetn <= 1'b1;
        // nothing may come out while idle after reset
        repeat (6) begin
            @(posedge clk);
            checks++;
            if (q_valid !== 1'b0) begin
                errors++;
                $display("[FAIL] reset_state q_valid: expected 0 actual %b", q_valid);
            end
        end
        for (row = 0; row < NUM_ROWS; row++) begin
            if (aborted) begin
                break;
            end
            stream_row(row);
        end
        @(posedge clk);
        q_hold <= 1'b0;
        @(negedge clk);
        if (exp_q.size() != 0) begin
            errors++;
            $display("%0d expected results never appeared on the output", exp_q.size());
        end
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

//--- source/jpeg_quant.sv
`timescale 1ns/1ns

module jpeg_quant #(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  jpeg_quant_pkg::coef_pair_t       di,
    input  logic                             di_valid,
    input  logic [4:0]                       di_cnt,
    output logic                             di_hold,
    output jpeg_quant_pkg::quant_pair_t      q,
    output logic                             q_valid,
    output jpeg_quant_pkg::quant_side_t      q_side,
    input  logic                             q_hold,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1
);

    localparam int PW = jpeg_quant_pkg::DW + jpeg_quant_pkg::M_BITS;
    localparam int QW = jpeg_quant_pkg::QW;
    // product scale is 2^(M_BITS-1)
    localparam int SHIFT = jpeg_quant_pkg::M_BITS - 1;

    logic                         accept;
    logic                         en;
    logic [1:0]                   chroma;
    logic                         last_mcu;
    logic [5:0]                   ra;
    jpeg_quant_pkg::quant_side_t  side_in;
    jpeg_quant_pkg::coef_pair_t   di0;
    jpeg_quant_pkg::quant_side_t  di0_side;
    logic                         di0_valid;
    jpeg_quant_pkg::factor_pair_t factor;
    logic signed [PW-1:0]         prod0;
    logic signed [PW-1:0]         prod1;

    // the whole pipe stalls while the receiver holds
    assign en      = !q_hold;
    assign accept  = di_valid && !q_hold;
    assign di_hold = q_hold;

    mcu_tracker #(
        .SENSOR_X_SIZE(SENSOR_X_SIZE),
        .SENSOR_Y_SIZE(SENSOR_Y_SIZE)
    ) mcu_tracker_i (
        .clk      (clk),
        .resetn   (resetn),
        .accept   (accept),
        .di_cnt   (di_cnt),
        .x_size_m1(x_size_m1),
        .y_size_m1(y_size_m1),
        .chroma   (chroma),
        .last_mcu (last_mcu)
    );

    // U and V share the chroma half of the rom
    assign ra = {chroma != 2'd0, di_cnt};

    quant_tables quant_tables_i (
        .clk(clk),
        .re (accept),
        .ra (ra),
        .rd (factor)
    );

    assign side_in = '{last_mcu: last_mcu, chroma: chroma, cnt: di_cnt};

    // input register stage, in step with the rom read
    always_ff @(posedge clk) begin
        if (!resetn) begin
            di0_valid <= 1'b0;
        end else if (en) begin
            di0_valid <= di_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            di0      <= di;
            di0_side <= side_in;
        end
    end

    quant_mult mult0_i (
        .clk      (clk),
        .resetn   (resetn),
        .en       (en),
        .in_valid (di0_valid),
        .a_in     (di0.c0),
        .b_in     (factor.f0),
        .out      (prod0),
        .out_valid(q_valid)
    );

    // second lane runs in lockstep, its valid is the same as lane 0
    quant_mult mult1_i (
        .clk      (clk),
        .resetn   (resetn),
        .en       (en),
        .in_valid (di0_valid),
        .a_in     (di0.c1),
        .b_in     (factor.f1),
        .out      (prod1),
        .out_valid()
    );

    sideband_pipe #(
        .DEPTH(jpeg_quant_pkg::MULT_STAGES)
    ) sideband_pipe_i (
        .clk(clk),
        .en (en),
        .d  (di0_side),
        .q  (q_side)
    );

    // arithmetic shift right by SHIFT, low QW bits kept
    assign q = '{
        q0: prod0[SHIFT +: QW],
        q1: prod1[SHIFT +: QW]
    };

endmodule

//--- source/sideband_pipe.sv
`timescale 1ns/1ns

module sideband_pipe #(
    parameter int DEPTH = 4
) (
    input  logic                        clk,
    input  logic                        en,
    input  jpeg_quant_pkg::quant_side_t d,
    output jpeg_quant_pkg::quant_side_t q
);

    // one entry per multiplier stage
    jpeg_quant_pkg::quant_side_t stage [DEPTH];

    always_ff @(posedge clk) begin
        if (en) begin
            stage[0] <= d;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign q = stage[DEPTH-1];

endmodule

//--- source/mcu_tracker.sv
`timescale 1ns/1ns

module mcu_tracker #(
    parameter int SENSOR_X_SIZE = 1280,
    parameter int SENSOR_Y_SIZE = 720
) (
    input  logic                             clk,
    input  logic                             resetn,
    input  logic                             accept,
    input  logic [4:0]                       di_cnt,
    input  logic [$clog2(SENSOR_X_SIZE)-1:0] x_size_m1,
    input  logic [$clog2(SENSOR_Y_SIZE)-1:0] y_size_m1,
    output logic [1:0]                       chroma,
    output logic                             last_mcu
);

    localparam int XW = $clog2(SENSOR_X_SIZE);
    localparam int YW = $clog2(SENSOR_Y_SIZE);

    // 0..3 Y, 4 U, 5 V
    logic [2:0]    blk_cnt;
    // mcu coordinates, 16 pixels per mcu
    logic [XW-5:0] x_mcu;
    logic [YW-5:0] y_mcu;
    logic [XW-5:0] x_last;
    logic [YW-5:0] y_last;
    logic          blk_end;
    logic          mcu_end;

    assign x_last = x_size_m1[XW-1:4];
    assign y_last = y_size_m1[YW-1:4];

    assign blk_end = accept && (di_cnt == 5'd31);
    assign mcu_end = blk_end && (blk_cnt == 3'd5);

    always_ff @(posedge clk) begin
        if (!resetn) begin
            blk_cnt <= '0;
            x_mcu   <= '0;
            y_mcu   <= '0;
        end else begin
            if (blk_end) begin
                blk_cnt <= (blk_cnt == 3'd5) ? 3'd0 : blk_cnt + 3'd1;
            end
            if (mcu_end) begin
                if (x_mcu == x_last) begin
                    x_mcu <= '0;
                    // wrap into the next frame after the bottom row
                    y_mcu <= (y_mcu == y_last) ? '0 : y_mcu + 1'b1;
                end else begin
                    x_mcu <= x_mcu + 1'b1;
                end
            end
        end
    end

    always_comb begin
        case (blk_cnt)
            3'd4:    chroma = 2'd1;
            3'd5:    chroma = 2'd2;
            default: chroma = 2'd0;
        endcase
    end

    assign last_mcu = (blk_cnt == 3'd5) && (x_mcu == x_last) && (y_mcu == y_last);

endmodule

//--- source/quant_mult.sv
`timescale 1ns/1ns

module quant_mult (
    input  logic                                                      clk,
    input  logic                                                      resetn,
    input  logic                                                      en,
    input  logic                                                      in_valid,
    input  logic signed [jpeg_quant_pkg::DW-1:0]                      a_in,
    input  logic [jpeg_quant_pkg::M_BITS-1:0]                         b_in,
    output logic signed [jpeg_quant_pkg::DW+jpeg_quant_pkg::M_BITS-1:0] out,
    output logic                                                      out_valid
);

    localparam int AW = jpeg_quant_pkg::DW;
    localparam int BW = jpeg_quant_pkg::M_BITS;
    localparam int PW = AW + BW;
    localparam int NS = jpeg_quant_pkg::MULT_STAGES;
    // b is split into a low and a high slice
    localparam int LO_W = BW / 2 + 1;
    localparam int HI_W = BW - LO_W;

    logic signed [AW-1:0]   a_r;
    logic [BW-1:0]          b_r;
    // one spare bit each for the zero-extended unsigned slice
    logic signed [AW+LO_W:0] pp_lo;
    logic signed [AW+HI_W:0] pp_hi;
    logic signed [PW-1:0]    sum;
    logic [NS-1:0]           vld;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            vld <= '0;
        end else if (en) begin
            vld <= {vld[NS-2:0], in_valid};
        end
    end

    always_ff @(posedge clk) begin
        if (en) begin
            // stage 1: register operands
            a_r <= a_in;
            b_r <= b_in;
            // stage 2: partial products
            pp_lo <= a_r * $signed({1'b0, b_r[LO_W-1:0]});
            pp_hi <= a_r * $signed({1'b0, b_r[BW-1:LO_W]});
            // stage 3: align and add
            sum <= PW'(pp_lo) + (PW'(pp_hi) <<< LO_W);
            // stage 4: output register
            out <= sum;
        end
    end

    assign out_valid = vld[NS-1];

endmodule

//--- source/quant_tables.sv
`timescale 1ns/1ns

module quant_tables (
    input  logic                         clk,
    input  logic                         re,
    input  logic [5:0]                   ra,
    output jpeg_quant_pkg::factor_pair_t rd
);

    localparam int MB = jpeg_quant_pkg::M_BITS;
    // unity gain of the reciprocal, matches the output shift of M_BITS-1
    localparam int ONE = 1 << (MB - 1);

    // rounded reciprocal of one table entry, addressed by zigzag index
    function automatic logic [MB-1:0] recip(input int chroma_sel, input int zz);
        int raster;
        int qstd;
        raster = int'(jpeg_quant_pkg::ZIGZAG_RASTER[zz]);
        if (chroma_sel != 0) begin
            qstd = int'(jpeg_quant_pkg::STD_CHROMA_Q[raster]);
        end else begin
            qstd = int'(jpeg_quant_pkg::STD_LUMA_Q[raster]);
        end
        // round to nearest
        return MB'((ONE + qstd / 2) / qstd);
    endfunction

    // word i holds the factors for zigzag indices 2*cnt and 2*cnt+1,
    // the upper 32 words are the chroma half
    jpeg_quant_pkg::factor_pair_t rom [64];

    for (genvar i = 0; i < 64; i++) begin : g_rom
        localparam int SEL = i / 32;
        localparam int CNT = i % 32;

        assign rom[i] = '{
            f0: recip(SEL, 2 * CNT),
            f1: recip(SEL, 2 * CNT + 1)
        };
    end

    // registered read, lines up with the input register stage of the top
    always_ff @(posedge clk) begin
        if (re) begin
            rd <= rom[ra];
        end
    end

endmodule

//--- source/jpeg_quant_pkg.sv
package jpeg_quant_pkg;

    // coefficient, quantized value and reciprocal widths
    localparam int DW = 15;
    localparam int QW = 11;
    localparam int M_BITS = 13;

    localparam int MULT_STAGES = 4;
    // input register stage plus the multiplier
    localparam int QUANT_LATENCY = 1 + MULT_STAGES;

    // c0 carries the even zigzag index, c1 the odd one
    typedef struct packed {
        logic signed [DW-1:0] c0;
        logic signed [DW-1:0] c1;
    } coef_pair_t;

    typedef struct packed {
        logic signed [QW-1:0] q0;
        logic signed [QW-1:0] q1;
    } quant_pair_t;

    typedef struct packed {
        logic [M_BITS-1:0] f0;
        logic [M_BITS-1:0] f1;
    } factor_pair_t;

    // chroma: 0 Y, 1 U, 2 V
    typedef struct packed {
        logic       last_mcu;
        logic [1:0] chroma;
        logic [4:0] cnt;
    } quant_side_t;

    // annex K luminance table, raster order
    localparam logic [7:0] STD_LUMA_Q [64] = '{
        16, 11, 10, 16, 24, 40, 51, 61,
        12, 12, 14, 19, 26, 58, 60, 55,
        14, 13, 16, 24, 40, 57, 69, 56,
        14, 17, 22, 29, 51, 87, 80, 62,
        18, 22, 37, 56, 68, 109, 103, 77,
        24, 35, 55, 64, 81, 104, 113, 92,
        49, 64, 78, 87, 103, 121, 120, 101,
        72, 92, 95, 98, 112, 100, 103, 99
    };

    // annex K chrominance table, raster order
    localparam logic [7:0] STD_CHROMA_Q [64] = '{
        17, 18, 24, 47, 99, 99, 99, 99,
        18, 21, 26, 66, 99, 99, 99, 99,
        24, 26, 56, 99, 99, 99, 99, 99,
        47, 66, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99,
        99, 99, 99, 99, 99, 99, 99, 99
    };

    // zigzag index to raster index
    localparam logic [5:0] ZIGZAG_RASTER [64] = '{
        0, 1, 8, 16, 9, 2, 3, 10,
        17, 24, 32, 25, 18, 11, 4, 5,
        12, 19, 26, 33, 40, 48, 41, 34,
        27, 20, 13, 6, 7, 14, 21, 28,
        35, 42, 49, 56, 57, 50, 43, 36,
        29, 22, 15, 23, 30, 37, 44, 51,
        58, 59, 52, 45, 38, 31, 39, 46,
        53, 60, 61, 54, 47, 55, 62, 63
    };

endpackage
